//--- common/mopshub_pkg.sv
package mopshub_pkg;

  // Hub geometry
  localparam int N_BUSES   = 8;
  localparam int BUS_SEL_W = $clog2(N_BUSES);
  localparam int BUS_ID_W  = 5;
  // First bus number with no bus behind it
  localparam logic [BUS_ID_W-1:0] BUS_ID_LIMIT = BUS_ID_W'(N_BUSES);

  // E-link framing, two bits per transfer
  localparam int DIBITS_PER_FRAME = 38;
  localparam int DIBIT_CNT_W      = $clog2(DIBITS_PER_FRAME);
  localparam logic [DIBIT_CNT_W-1:0] LAST_DIBIT = DIBIT_CNT_W'(DIBITS_PER_FRAME - 1);

  // One bit per bus
  typedef logic [N_BUSES-1:0] bus_mask_t;

  // CAN payload as seen by a bus controller
  typedef struct packed {
    logic [10:0] can_id;
    logic [3:0]  dlc;
    logic [55:0] data;
  } can_frame_t;

  // Frame as carried over the e-link
  typedef struct packed {
    logic [BUS_ID_W-1:0] bus_id;
    can_frame_t          can;
  } elink_frame_t;

  localparam int ELINK_FRAME_W = $bits(elink_frame_t);

endpackage

//--- elink/elink_deserializer.sv
`timescale 1ns/100ps

module elink_deserializer (
  input  logic                      clk_40_m,
  input  logic                      rst,
  input  logic                      sof,
  input  logic [1:0]                data,
  output mopshub_pkg::elink_frame_t frame,
  output logic                      frame_strobe
);

  logic [mopshub_pkg::DIBIT_CNT_W-1:0] cnt;
  logic                                active;

  // Dibit counter, restarted by every start pulse
  always_ff @(posedge clk_40_m)
  begin
    if (!rst)
    begin
      active       <= 1'b0;
      cnt          <= '0;
      frame_strobe <= 1'b0;
    end
    else
    begin
      frame_strobe <= 1'b0;
      if (sof)
      begin
        active <= 1'b1;
        cnt    <= 1;
      end
      else if (active)
      begin
        if (cnt == mopshub_pkg::LAST_DIBIT)
        begin
          active       <= 1'b0;
          cnt          <= '0;
          frame_strobe <= 1'b1;
        end
        else
          cnt <= cnt + 1'b1;
      end
    end
  end

  // MSB first, so new dibits enter at the bottom
  always_ff @(posedge clk_40_m)
  begin
    if (sof || active)
      frame <= {frame[mopshub_pkg::ELINK_FRAME_W-3:0], data};
  end

  // A full frame takes 38 cycles, strobes can never touch
  assert property (@(posedge clk_40_m) disable iff (!rst)
    frame_strobe |=> !frame_strobe);

endmodule

//--- elink/elink_serializer.sv
`timescale 1ns/100ps

module elink_serializer (
  input  logic                      clk_40_m,
  input  logic                      rst,
  input  mopshub_pkg::elink_frame_t head,
  input  logic                      empty,
  output logic                      pop,
  output logic                      sof,
  output logic [1:0]                data
);

  logic [mopshub_pkg::ELINK_FRAME_W-1:0] shift_reg;
  logic [mopshub_pkg::DIBIT_CNT_W-1:0]   cnt;
  logic                                  active;
  logic                                  last_dibit;

  assign last_dibit = (cnt == mopshub_pkg::LAST_DIBIT);

  // Take the next frame when idle or while the last dibit goes out
  assign pop = !empty && (!active || last_dibit);

  always_ff @(posedge clk_40_m)
  begin
    if (!rst)
    begin
      active <= 1'b0;
      cnt    <= '0;
      sof    <= 1'b0;
      data   <= '0;
    end
    else if (pop)
    begin
      active <= 1'b1;
      cnt    <= '0;
      sof    <= 1'b1;
      data   <= head[mopshub_pkg::ELINK_FRAME_W-1 -: 2];
    end
    else if (active && !last_dibit)
    begin
      cnt  <= cnt + 1'b1;
      sof  <= 1'b0;
      data <= shift_reg[mopshub_pkg::ELINK_FRAME_W-1 -: 2];
    end
    else
    begin
      // Line goes quiet
      active <= 1'b0;
      cnt    <= '0;
      sof    <= 1'b0;
      data   <= '0;
    end
  end

  // Holds the dibits not yet on the line, top aligned
  always_ff @(posedge clk_40_m)
  begin
    if (pop)
      shift_reg <= {head[mopshub_pkg::ELINK_FRAME_W-3:0], 2'b00};
    else if (active)
      shift_reg <= {shift_reg[mopshub_pkg::ELINK_FRAME_W-3:0], 2'b00};
  end

  assert property (@(posedge clk_40_m) disable iff (!rst)
    sof |-> (cnt == '0) && active);

endmodule

//--- verilog/frame_fifo.sv
`timescale 1ns/100ps

module frame_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                      clk_40_m,
  input  logic                      rst,
  input  mopshub_pkg::elink_frame_t wr_frame,
  input  logic                      wr_strobe,
  input  logic                      rd_pop,
  output mopshub_pkg::elink_frame_t rd_frame,
  output logic                      empty,
  output logic                      full,
  output logic                      overflow
);

  mopshub_pkg::elink_frame_t mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]  wr_ptr;
  logic [$clog2(DEPTH)-1:0]  rd_ptr;
  logic [$clog2(DEPTH):0]    count;
  logic                      do_write;
  logic                      do_read;

  assign empty    = (count == '0);
  // DEPTH is a power of two, so the top bit alone means full
  assign full     = count[$clog2(DEPTH)];
  assign do_write = wr_strobe && !full;
  assign do_read  = rd_pop && !empty;
  assign rd_frame = mem[rd_ptr];

  always_ff @(posedge clk_40_m)
  begin
    if (!rst)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      overflow <= wr_strobe && full;
      if (do_write)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_read)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_write && !do_read)
        count <= count + 1'b1;
      else if (do_read && !do_write)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk_40_m)
  begin
    if (do_write)
      mem[wr_ptr] <= wr_frame;
  end

  // Readers must look at empty before popping
  assert property (@(posedge clk_40_m) disable iff (!rst) rd_pop |-> !empty);
  assert property (@(posedge clk_40_m) disable iff (!rst) count <= DEPTH);

endmodule

//--- verilog/downlink_router.sv
`timescale 1ns/100ps

module downlink_router (
  input  logic                      clk_40_m,
  input  logic                      rst,
  input  mopshub_pkg::elink_frame_t head,
  input  logic                      empty,
  input  mopshub_pkg::bus_mask_t    busy,
  output logic                      pop,
  output mopshub_pkg::can_frame_t   can_frame,
  output mopshub_pkg::bus_mask_t    can_strobe,
  output logic                      err_bus_id
);

  logic [mopshub_pkg::BUS_SEL_W-1:0] bus_sel;
  logic                              bus_ok;
  logic                              target_busy;

  assign bus_sel     = head.bus_id[mopshub_pkg::BUS_SEL_W-1:0];
  assign bus_ok      = (head.bus_id < mopshub_pkg::BUS_ID_LIMIT);
  assign target_busy = busy[bus_sel];

  // Bad bus numbers leave at once, good ones wait for their bus
  assign pop = !empty && (!bus_ok || !target_busy);

  always_ff @(posedge clk_40_m)
  begin
    if (!rst)
    begin
      can_strobe <= '0;
      err_bus_id <= 1'b0;
    end
    else
    begin
      can_strobe <= '0;
      err_bus_id <= 1'b0;
      if (pop)
      begin
        if (bus_ok)
          can_strobe <= mopshub_pkg::bus_mask_t'(1) << bus_sel;
        else
          err_bus_id <= 1'b1;
      end
    end
  end

  // Payload shared by all buses, qualified by the strobe
  always_ff @(posedge clk_40_m)
  begin
    if (pop && bus_ok)
      can_frame <= head.can;
  end

  assert property (@(posedge clk_40_m) disable iff (!rst) $onehot0(can_strobe));

endmodule

//--- verilog/uplink_arbiter.sv
`timescale 1ns/100ps

module uplink_arbiter (
  input  logic                      clk_40_m,
  input  logic                      rst,
  input  mopshub_pkg::can_frame_t   rx_frame [mopshub_pkg::N_BUSES],
  input  mopshub_pkg::bus_mask_t    rx_strobe,
  input  logic                      full,
  output mopshub_pkg::elink_frame_t push_frame,
  output logic                      push_strobe,
  output logic                      overflow
);

  mopshub_pkg::can_frame_t           rsp_buf [mopshub_pkg::N_BUSES];
  mopshub_pkg::bus_mask_t            pending;
  mopshub_pkg::bus_mask_t            accept;
  mopshub_pkg::bus_mask_t            grant_mask;
  logic [mopshub_pkg::BUS_SEL_W-1:0] rr_ptr;
  logic [mopshub_pkg::BUS_SEL_W-1:0] grant_sel;
  logic                              grant_valid;

  // Only empty slots take a new response
  assign accept = rx_strobe & ~pending;

  // Search from the pointer upward, nearest pending bus wins
  always_comb
  begin
    logic [mopshub_pkg::BUS_SEL_W-1:0] idx;
    grant_valid = 1'b0;
    grant_sel   = rr_ptr;
    for (int k = mopshub_pkg::N_BUSES - 1; k >= 0; k--)
    begin
      idx = rr_ptr + k[mopshub_pkg::BUS_SEL_W-1:0];
      if (pending[idx])
      begin
        grant_valid = 1'b1;
        grant_sel   = idx;
      end
    end
  end

  assign push_strobe = grant_valid && !full;
  assign grant_mask  = push_strobe ? mopshub_pkg::bus_mask_t'(1) << grant_sel : '0;

  // Tag the response with the bus it came from
  always_comb
  begin
    push_frame        = '0;
    push_frame.can    = rsp_buf[grant_sel];
    push_frame.bus_id[mopshub_pkg::BUS_SEL_W-1:0] = grant_sel;
  end

  always_ff @(posedge clk_40_m)
  begin
    if (!rst)
    begin
      pending  <= '0;
      rr_ptr   <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      pending  <= (pending & ~grant_mask) | accept;
      overflow <= |(rx_strobe & pending);
      if (push_strobe)
        rr_ptr <= grant_sel + 1'b1;
    end
  end

  always_ff @(posedge clk_40_m)
  begin
    for (int i = 0; i < mopshub_pkg::N_BUSES; i++)
    begin
      if (accept[i])
        rsp_buf[i] <= rx_frame[i];
    end
  end

endmodule

//--- verilog/mopshub_core_top.sv
`timescale 1ns/100ps

module mopshub_core_top (
  input  logic                      clk_40_m,
  input  logic                      rst,
  input  logic                      elink_rx_sof,
  input  logic [1:0]                elink_rx_data,
  input  mopshub_pkg::bus_mask_t    can_tx_busy,
  input  mopshub_pkg::can_frame_t   can_rx_frame [mopshub_pkg::N_BUSES],
  input  mopshub_pkg::bus_mask_t    can_rx_strobe,
  output mopshub_pkg::can_frame_t   can_tx_frame,
  output mopshub_pkg::bus_mask_t    can_tx_strobe,
  output logic                      err_bus_id,
  output logic                      dl_overflow,
  output logic                      elink_tx_sof,
  output logic [1:0]                elink_tx_data,
  output logic                      can_rx_overflow
);

  // Downlink
  mopshub_pkg::elink_frame_t dl_frame;
  mopshub_pkg::elink_frame_t dl_head;
  logic                      dl_strobe;
  logic                      dl_empty;
  logic                      dl_pop;

  // Uplink
  mopshub_pkg::elink_frame_t ul_frame;
  mopshub_pkg::elink_frame_t ul_head;
  logic                      ul_push;
  logic                      ul_full;
  logic                      ul_empty;
  logic                      ul_pop;

  elink_deserializer deser_i (
    .clk_40_m     (clk_40_m),
    .rst          (rst),
    .sof          (elink_rx_sof),
    .data         (elink_rx_data),
    .frame        (dl_frame),
    .frame_strobe (dl_strobe)
  );

  frame_fifo #(.DEPTH(4)) dl_fifo_i (
    .clk_40_m  (clk_40_m),
    .rst       (rst),
    .wr_frame  (dl_frame),
    .wr_strobe (dl_strobe),
    .rd_pop    (dl_pop),
    .rd_frame  (dl_head),
    .empty     (dl_empty),
    .full      (),
    .overflow  (dl_overflow)
  );

  downlink_router router_i (
    .clk_40_m   (clk_40_m),
    .rst        (rst),
    .head       (dl_head),
    .empty      (dl_empty),
    .busy       (can_tx_busy),
    .pop        (dl_pop),
    .can_frame  (can_tx_frame),
    .can_strobe (can_tx_strobe),
    .err_bus_id (err_bus_id)
  );

  uplink_arbiter arbiter_i (
    .clk_40_m    (clk_40_m),
    .rst         (rst),
    .rx_frame    (can_rx_frame),
    .rx_strobe   (can_rx_strobe),
    .full        (ul_full),
    .push_frame  (ul_frame),
    .push_strobe (ul_push),
    .overflow    (can_rx_overflow)
  );

  // Arbiter never pushes into a full queue, its overflow stays open
  frame_fifo #(.DEPTH(4)) ul_fifo_i (
    .clk_40_m  (clk_40_m),
    .rst       (rst),
    .wr_frame  (ul_frame),
    .wr_strobe (ul_push),
    .rd_pop    (ul_pop),
    .rd_frame  (ul_head),
    .empty     (ul_empty),
    .full      (ul_full),
    .overflow  ()
  );

  elink_serializer ser_i (
    .clk_40_m (clk_40_m),
    .rst      (rst),
    .head     (ul_head),
    .empty    (ul_empty),
    .pop      (ul_pop),
    .sof      (elink_tx_sof),
    .data     (elink_tx_data)
  );

endmodule

//--- tests/tb_mopshub_core.sv
`timescale 1ns/100ps

module tb_mopshub_core;

  localparam int N_ROUTE   = 10;
  localparam int N_INVALID = 3;
  localparam int N_TAG     = 8;
  // Downlink and uplink frames over all tests
  localparam int N_FRAMES  = N_ROUTE + 2 * N_INVALID + 5 + mopshub_pkg::N_BUSES + 1 + N_TAG;
  localparam int TIMEOUT_CYCLES = N_FRAMES * mopshub_pkg::DIBITS_PER_FRAME + 2000;

  // One expected CAN strobe, cyc is -1 when latency is not checked
  typedef struct packed {
    int                      bus;
    int                      cyc;
    mopshub_pkg::can_frame_t can;
  } dl_expect_t;

  logic                      clk_40_m;
  logic                      rst;
  logic                      elink_rx_sof;
  logic [1:0]                elink_rx_data;
  mopshub_pkg::bus_mask_t    can_tx_busy;
  mopshub_pkg::can_frame_t   can_rx_frame [mopshub_pkg::N_BUSES];
  mopshub_pkg::bus_mask_t    can_rx_strobe;
  mopshub_pkg::can_frame_t   can_tx_frame;
  mopshub_pkg::bus_mask_t    can_tx_strobe;
  logic                      err_bus_id;
  logic                      dl_overflow;
  logic                      elink_tx_sof;
  logic [1:0]                elink_tx_data;
  logic                      can_rx_overflow;

  dl_expect_t                dl_expect [$];
  mopshub_pkg::elink_frame_t ul_expect [$];
  int                        exp_err     = 0;
  int                        exp_dl_ovf  = 0;
  int                        exp_rx_ovf  = 0;
  int                        error_count = 0;
  int                        check_count = 0;
  int                        test_count  = 0;
  int                        test_errors = 0;
  int                        cycle       = 0;
  int                        ul_cnt      = 0;
  logic [31:0]               lcg_state   = 32'hc17d;
  logic [mopshub_pkg::ELINK_FRAME_W-1:0] ul_shift;

  mopshub_core_top mopshub_core_top_i (
    .clk_40_m        (clk_40_m),
    .rst             (rst),
    .elink_rx_sof    (elink_rx_sof),
    .elink_rx_data   (elink_rx_data),
    .can_tx_busy     (can_tx_busy),
    .can_rx_frame    (can_rx_frame),
    .can_rx_strobe   (can_rx_strobe),
    .can_tx_frame    (can_tx_frame),
    .can_tx_strobe   (can_tx_strobe),
    .err_bus_id      (err_bus_id),
    .dl_overflow     (dl_overflow),
    .elink_tx_sof    (elink_tx_sof),
    .elink_tx_data   (elink_tx_data),
    .can_rx_overflow (can_rx_overflow)
  );

  initial
  begin
    clk_40_m = 1'b0;
    forever
      #10 clk_40_m = ~clk_40_m;
  end

  // Cycle count, read at falling edges only
  always @(posedge clk_40_m)
    cycle <= cycle + 1;

  task automatic report_error(input string msg);
    error_count++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  task automatic expect_true(input bit ok, input string msg);
    check_count++;
    assert (ok) else report_error(msg);
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int random_bus();
    logic [31:0] r;
    r = next_rand();
    return int'(r[30:28]);
  endfunction

  function automatic mopshub_pkg::can_frame_t random_can();
    mopshub_pkg::can_frame_t c;
    logic [31:0]             r;
    logic [63:0]             d;
    r = next_rand();
    d = {next_rand(), next_rand()};
    c.can_id = r[31:21];
    c.dlc    = r[19:16];
    c.data   = d[55:0];
    return c;
  endfunction

  function automatic mopshub_pkg::elink_frame_t make_frame(input int bus);
    mopshub_pkg::elink_frame_t f;
    f.bus_id = bus[mopshub_pkg::BUS_ID_W-1:0];
    f.can    = random_can();
    return f;
  endfunction

  // MSB first, start pulse with the first dibit
  task automatic send_elink(input mopshub_pkg::elink_frame_t f, output int last_cyc);
    for (int i = 0; i < mopshub_pkg::DIBITS_PER_FRAME; i++)
    begin
      @(negedge clk_40_m);
      elink_rx_sof  = (i == 0);
      elink_rx_data = f[mopshub_pkg::ELINK_FRAME_W-1-2*i -: 2];
    end
    last_cyc = cycle;
    @(negedge clk_40_m);
    elink_rx_sof  = 1'b0;
    elink_rx_data = 2'b00;
  endtask

  task automatic send_routed(input mopshub_pkg::elink_frame_t f, input bit timed);
    int         last_cyc;
    dl_expect_t e;
    send_elink(f, last_cyc);
    e.bus = int'(f.bus_id);
    e.can = f.can;
    // Strobe seen 3 cycles after the last dibit
    e.cyc = timed ? last_cyc + 3 : -1;
    dl_expect.push_back(e);
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while ((dl_expect.size() != 0 || ul_expect.size() != 0) && n < max_cycles)
    begin
      @(negedge clk_40_m);
      n++;
    end
    if (n >= max_cycles)
    begin
      error_count++;
      $display("Expected frames still outstanding after %0d cycles", max_cycles);
    end
    repeat (4) @(negedge clk_40_m);
  endtask

  task automatic report_test(input string name);
    test_count++;
    if (error_count == test_errors)
      $display("Test %0d %s: ok", test_count, name);
    else
      $display("Test %0d %s: %0d errors", test_count, name, error_count - test_errors);
    test_errors = error_count;
  endtask

  task automatic check_quiet(input string when);
    expect_true(can_tx_strobe == '0 && !err_bus_id && !dl_overflow && !can_rx_overflow &&
                !elink_tx_sof && elink_tx_data == 2'b00, {"outputs not idle ", when});
  endtask

  task automatic check_reset_state();
    for (int i = 0; i < 5; i++)
    begin
      @(negedge clk_40_m);
      check_quiet("during reset");
    end
    rst = 1'b1;
    repeat (3)
    begin
      @(negedge clk_40_m);
      check_quiet("after reset");
    end
  endtask

  task automatic route_frames();
    repeat (N_ROUTE)
      send_routed(make_frame(random_bus()), 1'b1);
    wait_drain(100);
  endtask

  task automatic reject_bad_bus();
    int          last_cyc;
    logic [31:0] r;
    for (int i = 0; i < N_INVALID; i++)
    begin
      r = next_rand();
      send_elink(make_frame(mopshub_pkg::N_BUSES + int'(r[31:27]) % 24), last_cyc);
      exp_err++;
      send_routed(make_frame(random_bus()), 1'b1);
    end
    wait_drain(100);
    expect_true(exp_err == 0, "err_bus_id pulse missing");
  endtask

  task automatic hold_on_busy();
    int b;
    int last_cyc;
    b = random_bus();
    @(negedge clk_40_m);
    can_tx_busy[b] = 1'b1;
    send_routed(make_frame(b), 1'b0);
    repeat (3)
      send_routed(make_frame(random_bus()), 1'b0);
    // Queue is full behind the blocked head
    send_elink(make_frame(random_bus()), last_cyc);
    exp_dl_ovf++;
    repeat (20) @(negedge clk_40_m);
    expect_true(dl_expect.size() == 4, "frames left the queue while the head bus was busy");
    can_tx_busy = '0;
    wait_drain(100);
    expect_true(exp_dl_ovf == 0, "dl_overflow pulse missing");
  endtask

  task automatic arbitrate_all_buses();
    mopshub_pkg::elink_frame_t f;
    @(negedge clk_40_m);
    for (int k = 0; k < mopshub_pkg::N_BUSES; k++)
    begin
      f = make_frame(k);
      can_rx_frame[k] = f.can;
      ul_expect.push_back(f);
    end
    can_rx_strobe = '1;
    @(negedge clk_40_m);
    // Last bus still waits for its grant
    can_rx_frame[mopshub_pkg::N_BUSES-1] = random_can();
    can_rx_strobe = mopshub_pkg::bus_mask_t'(1) << (mopshub_pkg::N_BUSES - 1);
    exp_rx_ovf++;
    @(negedge clk_40_m);
    can_rx_strobe = '0;
    wait_drain(mopshub_pkg::N_BUSES * mopshub_pkg::DIBITS_PER_FRAME + 100);
    expect_true(exp_rx_ovf == 0, "can_rx_overflow pulse missing");
  endtask

  task automatic tag_responses();
    int                        j;
    mopshub_pkg::elink_frame_t f;
    for (int t = 0; t < N_TAG; t++)
    begin
      j = random_bus();
      f = make_frame(j);
      @(negedge clk_40_m);
      can_rx_frame[j]  = f.can;
      can_rx_strobe[j] = 1'b1;
      ul_expect.push_back(f);
      @(negedge clk_40_m);
      can_rx_strobe = '0;
      wait_drain(mopshub_pkg::DIBITS_PER_FRAME + 100);
    end
  endtask

  // CAN side scoreboard and error pulses
  always @(negedge clk_40_m)
  begin : dl_monitor
    dl_expect_t e;
    if (rst)
    begin
      if (can_tx_strobe != '0)
      begin
        if (dl_expect.size() == 0)
          report_error($sformatf("unexpected CAN strobe %b", can_tx_strobe));
        else
        begin
          e = dl_expect.pop_front();
          expect_true(can_tx_strobe == (mopshub_pkg::bus_mask_t'(1) << e.bus),
                      $sformatf("CAN strobe %b, expected bus %0d", can_tx_strobe, e.bus));
          expect_true(can_tx_frame == e.can,
                      $sformatf("CAN frame %h, expected %h", can_tx_frame, e.can));
          if (e.cyc >= 0)
            expect_true(cycle == e.cyc,
                        $sformatf("CAN strobe in cycle %0d, expected %0d", cycle, e.cyc));
        end
      end
      if (err_bus_id)
      begin
        expect_true(exp_err > 0, "unexpected err_bus_id pulse");
        if (exp_err > 0)
          exp_err--;
      end
      if (dl_overflow)
      begin
        expect_true(exp_dl_ovf > 0, "unexpected dl_overflow pulse");
        if (exp_dl_ovf > 0)
          exp_dl_ovf--;
      end
      if (can_rx_overflow)
      begin
        expect_true(exp_rx_ovf > 0, "unexpected can_rx_overflow pulse");
        if (exp_rx_ovf > 0)
          exp_rx_ovf--;
      end
    end
  end

  // Rebuilds uplink frames from the e-link
  always @(negedge clk_40_m)
  begin : ul_monitor
    mopshub_pkg::elink_frame_t e;
    if (rst)
    begin
      if (elink_tx_sof)
      begin
        if (ul_cnt != 0)
          report_error("uplink frame cut short by a new start pulse");
        ul_shift      = '0;
        ul_shift[1:0] = elink_tx_data;
        ul_cnt        = 1;
      end
      else if (ul_cnt != 0)
      begin
        ul_shift = {ul_shift[mopshub_pkg::ELINK_FRAME_W-3:0], elink_tx_data};
        ul_cnt++;
      end
      if (ul_cnt == mopshub_pkg::DIBITS_PER_FRAME)
      begin
        ul_cnt = 0;
        if (ul_expect.size() == 0)
          report_error($sformatf("unexpected uplink frame %h", ul_shift));
        else
        begin
          e = ul_expect.pop_front();
          expect_true(ul_shift == e, $sformatf("uplink frame %h, expected %h", ul_shift, e));
        end
      end
    end
  end

  // Strobe decided on the busy level one edge earlier
  assert property (@(posedge clk_40_m) disable iff (!rst)
    (can_tx_strobe & $past(can_tx_busy)) == '0)
  else report_error("CAN strobe issued to a busy bus");

  assert property (@(posedge clk_40_m) disable iff (!rst)
    err_bus_id |-> (can_tx_strobe == '0))
  else report_error("CAN strobe together with err_bus_id");

  assert property (@(posedge clk_40_m) disable iff (!rst)
    elink_tx_sof |=> !elink_tx_sof)
  else report_error("elink_tx_sof high for two cycles");

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_40_m);
    $display("Watchdog expired after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    rst           = 1'b0;
    elink_rx_sof  = 1'b0;
    elink_rx_data = 2'b00;
    can_tx_busy   = '0;
    can_rx_strobe = '0;
    for (int k = 0; k < mopshub_pkg::N_BUSES; k++)
      can_rx_frame[k] = '0;
    check_reset_state();
    report_test("reset state");
    route_frames();
    report_test("downlink routing");
    reject_bad_bus();
    report_test("invalid bus number");
    hold_on_busy();
    report_test("back-pressure");
    // Runs before any other uplink traffic so the pointer is still at bus 0
    arbitrate_all_buses();
    report_test("round robin");
    tag_responses();
    report_test("uplink tagging");
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verilog.f
common/mopshub_pkg.sv
elink/elink_deserializer.sv
elink/elink_serializer.sv
verilog/frame_fifo.sv
verilog/downlink_router.sv
verilog/uplink_arbiter.sv
verilog/mopshub_core_top.sv
tests/tb_mopshub_core.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert --timescale 1ns/100ps
TOP      = tb_mopshub_core
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
